//--- project.f
logic/imem_pkg.sv
logic/instruction_memory.sv
logic/imem_arbiter.sv
logic/apb_store_port.sv
logic/fetch_unit.sv
logic/imem_top.sv
test/tb_clock.sv
test/imem_assert.sv
test/imem_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = imem_tb
FILES = project.f

SRCS := $(shell grep -v '^+' $(FILES))

.PHONY: all run clean

all: run

obj_dir/V%: $(SRCS) $(FILES)
	$(TOOL) $(FLAGS) --top-module $* -f $(FILES)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/imem_tb.sv
// Instruction memory subsystem testbench
`timescale 1ns/1ps

module imem_tb;
  import imem_pkg::*;

  localparam int    MEM_SIZE = 4096;
  localparam addr_t PC_MASK  = addr_t'(MEM_SIZE - 1);
  localparam int    DRV      = 2;    // ns after the rising edge
  localparam int    LIMIT    = 200;  // Cycles per wait

  logic clk, rst_n;
  addr_t paddr, redirect_pc, instr_pc, exp_pc, last_pc;
  logic psel, penable, pwrite, pready, pslverr;
  word_t pwdata, prdata, instr, exp_w;
  strb_t pstrb;
  logic redirect, instr_compressed, instr_valid, instr_ready, exp_c;
  logic [7:0]  ref_mem [MEM_SIZE];  // Mirror of completed APB writes
  logic [15:0] lfsr_state = 16'd32797;
  int checks = 0, errors = 0, tests = 0, beat_count = 0;

  // Mixed RVC and 32-bit program, halfword by halfword from address 0
  logic [15:0] prog [18] = '{16'h0505, 16'h0093, 16'h0010, 16'h4501, 16'h81B3, 16'h0020,
                             16'h852E, 16'h0113, 16'hFFF1, 16'h0001, 16'h9002, 16'h0297,
                             16'h0000, 16'h4585, 16'h0513, 16'h0050, 16'h8082, 16'h0001};

  tb_clock u_clock (.clk, .rst_n);

  imem_top #(.MEM_SIZE(MEM_SIZE)) dut (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb,
    .prdata, .pready, .pslverr, .redirect, .redirect_pc,
    .instr, .instr_pc, .instr_compressed, .instr_valid, .instr_ready
  );

  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      ref_mem[i] = nop_instr[8*(i%4) +: 8];  // Little-endian NOP fill
    end
  end

  // Taps 16,14,13,11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // Four bytes from a, wrapping at the top of memory
  function automatic word_t mem_word(addr_t a);
    word_t w;
    for (int k = 0; k < 4; k++) w[8*k +: 8] = ref_mem[int'((a + addr_t'(k)) & PC_MASK)];
    return w;
  endfunction

  // Expected fetch beat at pc
  function automatic word_t ref_instr(addr_t pc);
    word_t w;
    w = mem_word(pc & ~addr_t'(1));
    return is_compressed(w) ? {16'h0000, w[15:0]} : w;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout: no progress while waiting for %s", what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic end_test(input string name, input int err_start);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "FAILED");
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input addr_t a, input word_t d, input strb_t s,
                          output word_t rd, output logic err);
    int   cnt;
    int   lat;
    logic done;
    cnt  = 0;
    done = 1'b0;
    lat  = (wr || a >= addr_t'(MEM_SIZE)) ? 1 : 2;  // Access cycles until pready
    @(posedge clk);
    #DRV;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    pstrb   = s;
    @(posedge clk);
    #DRV penable = 1'b1;
    while (!done) begin
      @(negedge clk);
      check_flag("pready", pready, cnt + 1 == lat);
      if (pready) begin
        rd   = prdata;
        err  = pslverr;
        done = 1'b1;
      end else if (cnt >= LIMIT) timeout_abort("pready");
      else cnt++;
    end
    @(posedge clk);
    #DRV psel = 1'b0;
    penable = 1'b0;
    if (wr && !err) begin
      for (int b = 0; b < 4; b++) begin
        if (s[b]) ref_mem[int'(((a & ~addr_t'(3)) + addr_t'(b)) & PC_MASK)] = d[8*b +: 8];
      end
    end
  endtask

  task automatic apb_read_check(input addr_t a);
    word_t rd;
    logic  err;
    apb_xfer(1'b0, a, '0, '0, rd, err);
    check_flag("pslverr", err, 1'b0);
    check_word("prdata", rd, mem_word(a & ~addr_t'(3)));
  endtask

  task automatic write_half(input addr_t a, input logic [15:0] h);
    word_t rd;
    logic  err;
    apb_xfer(1'b1, a, a[1] ? {h, 16'h0000} : {16'h0000, h}, a[1] ? 4'b1100 : 4'b0011, rd, err);
    check_flag("pslverr", err, 1'b0);
  endtask

  task automatic do_redirect(input addr_t pc);
    @(posedge clk);
    #DRV;
    instr_ready = 1'b0;  // No handshake while the stream restarts
    redirect = 1'b1;
    redirect_pc = pc;
    exp_pc = pc;
    @(posedge clk);
    #DRV redirect = 1'b0;
  endtask

  // Accept n beats, ready either steady or from the LFSR
  task automatic run_stream(input int n, input logic random_ready);
    int target, cnt;
    target = beat_count + n;
    cnt    = 0;
    while (beat_count < target && cnt < LIMIT * n) begin
      cnt++;
      @(posedge clk);
      #DRV instr_ready = random_ready ? lfsr_bit() : 1'b1;
    end
    instr_ready = 1'b0;
    if (beat_count < target) timeout_abort("fetch beats");
  endtask

  // Compare every accepted beat against the reference walk
  always @(negedge clk) begin
    if (rst_n && instr_valid && instr_ready && !redirect) begin
      exp_w = ref_instr(exp_pc);
      exp_c = is_compressed(exp_w);
      check_addr("instr_pc", instr_pc, exp_pc);
      check_word("instr", instr, exp_w);
      check_flag("instr_compressed", instr_compressed, exp_c);
      last_pc = instr_pc;
      exp_pc = (exp_pc + (exp_c ? addr_t'(2) : addr_t'(4))) & PC_MASK;
      beat_count++;
    end
  end

  initial begin
    int    e0, cnt;
    word_t rd;
    logic  err;
    addr_t a;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pstrb       = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    instr_ready = 1'b0;
    exp_pc      = '0;
    last_pc     = '0;
    cnt         = 0;
    while (rst_n !== 1'b1 && cnt < LIMIT) begin
      cnt++;
      @(posedge clk);
    end
    if (rst_n !== 1'b1) timeout_abort("reset release");

    e0 = errors;
    @(negedge clk);
    check_flag("instr_valid", instr_valid, 1'b0);  // Fetch idle until the first redirect
    check_flag("pready", pready, 1'b0);
    check_flag("pslverr", pslverr, 1'b0);
    apb_read_check(32'h0000);
    apb_read_check(32'h0124);
    apb_read_check(32'h0800);
    apb_read_check(32'h0FFC);
    end_test("reset contents", e0);

    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      a = 32'h0400 + (rand_bits(6) << 2);
      apb_xfer(1'b1, a, rand_bits(32), strb_t'(rand_bits(4)), rd, err);
      check_flag("pslverr", err, 1'b0);
      apb_read_check(a);
    end
    end_test("byte-lane writes", e0);

    e0 = errors;
    apb_xfer(1'b1, addr_t'(MEM_SIZE) + 32'h0404, 32'hDEAD_BEEF, 4'hF, rd, err);
    check_flag("pslverr", err, 1'b1);  // Aliases 0x404 if the range check fails
    apb_xfer(1'b0, 32'h8000_0000, '0, '0, rd, err);
    check_flag("pslverr", err, 1'b1);
    apb_read_check(32'h0404);
    end_test("out of range", e0);

    e0 = errors;
    for (int i = 0; i < 18; i++) write_half(addr_t'(2 * i), prog[i]);
    do_redirect(32'h0000);
    run_stream(14, 1'b0);
    end_test("mixed length fetch", e0);

    e0 = errors;
    do_redirect(32'h0000);
    fork
      run_stream(40, 1'b1);
      for (int i = 0; i < 10; i++) begin
        apb_xfer(1'b1, 32'h0800 + addr_t'(4 * i), rand_bits(32), 4'hF, rd, err);
      end
    join
    end_test("back-pressure with APB traffic", e0);

    e0 = errors;
    run_stream(3, 1'b0);
    do_redirect(32'h000E);  // 32-bit instruction at an odd halfword
    run_stream(1, 1'b0);
    check_addr("instr_pc", last_pc, 32'h000E);
    run_stream(4, 1'b0);
    end_test("mid-stream redirect", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- test/imem_assert.sv
// Arbiter grant checks
`timescale 1ns/1ps

module imem_assert (
  input logic clk,
  input logic rst_n,
  input logic apb_req,
  input logic apb_gnt,
  input logic fetch_req,
  input logic fetch_gnt
);

  // Single memory port, one owner per cycle
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(apb_gnt && fetch_gnt))
    else $error("both peers granted");

  a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (!apb_gnt || apb_req) && (!fetch_gnt || fetch_req))
    else $error("grant without request");

  // Fetch only loses to a live APB request
  a_fetch_served: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_req && !apb_req) |-> fetch_gnt)
    else $error("idle port left fetch waiting");

endmodule

bind imem_arbiter imem_assert u_assert (
  .clk, .rst_n, .apb_req, .apb_gnt, .fetch_req, .fetch_gnt
);

//--- test/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD = 50,  // 100 ns clock
  parameter int RST_CYCLES  = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Release a little after the edge, like other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

//--- logic/imem_top.sv
// Instruction memory subsystem top
`timescale 1ns/1ps

module imem_top #(
  parameter int MEM_SIZE = 4096
) (
  input  logic            clk,
  input  logic            rst_n,
  // APB4 slave
  input  imem_pkg::addr_t paddr,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  imem_pkg::word_t pwdata,
  input  imem_pkg::strb_t pstrb,
  output imem_pkg::word_t prdata,
  output logic            pready,
  output logic            pslverr,
  // Redirect
  input  logic            redirect,
  input  imem_pkg::addr_t redirect_pc,
  // Fetch stream
  output imem_pkg::word_t instr,
  output imem_pkg::addr_t instr_pc,
  output logic            instr_compressed,
  output logic            instr_valid,
  input  logic            instr_ready
);
  import imem_pkg::*;

  logic  apb_req, apb_we, apb_gnt;
  addr_t apb_addr;
  word_t apb_wdata;
  strb_t apb_strb;
  logic  fetch_req, fetch_gnt;
  addr_t fetch_addr;
  logic  mem_en, mem_we;
  addr_t mem_addr;
  word_t mem_wdata, mem_rdata;  // Read data shared by both peers
  strb_t mem_strb;

  apb_store_port #(.MEM_SIZE(MEM_SIZE)) u_apb (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
    .prdata, .pready, .pslverr,
    .req(apb_req), .we(apb_we), .addr(apb_addr), .wdata(apb_wdata),
    .strb(apb_strb), .gnt(apb_gnt), .rdata(mem_rdata)
  );

  fetch_unit #(.MEM_SIZE(MEM_SIZE)) u_fetch (
    .clk, .rst_n, .redirect, .redirect_pc,
    .req(fetch_req), .addr(fetch_addr), .gnt(fetch_gnt), .rdata(mem_rdata),
    .instr, .instr_pc, .instr_compressed, .instr_valid, .instr_ready
  );

  imem_arbiter u_arb (
    .clk, .rst_n,
    .apb_req, .apb_we, .apb_addr, .apb_wdata, .apb_strb, .apb_gnt,
    .fetch_req, .fetch_addr, .fetch_gnt,
    .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_strb
  );

  instruction_memory #(.MEM_SIZE(MEM_SIZE)) u_mem (
    .clk, .en(mem_en), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
    .strb(mem_strb), .rdata(mem_rdata)
  );

endmodule

//--- logic/fetch_unit.sv
// Sequential RVC-aware instruction fetcher
`timescale 1ns/1ps

module fetch_unit #(
  parameter int MEM_SIZE = 4096
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            redirect,     // Restart at redirect_pc
  input  imem_pkg::addr_t redirect_pc,
  output logic            req,
  output imem_pkg::addr_t addr,
  input  logic            gnt,
  input  imem_pkg::word_t rdata,
  output imem_pkg::word_t instr,
  output imem_pkg::addr_t instr_pc,
  output logic            instr_compressed,
  output logic            instr_valid,
  input  logic            instr_ready
);
  import imem_pkg::*;

  localparam addr_t PC_MASK = addr_t'(MEM_SIZE - 1);

  typedef enum logic [1:0] {
    st_idle,  // No stream yet
    st_req,   // Waiting for a grant
    st_wait,  // Read data arrives this cycle
    st_hold   // Beat on the output
  } state_t;

  state_t state;
  addr_t  pc;       // Address of the next read
  logic   accept;
  logic   rvc;      // Returned word is a 16-bit encoding
  addr_t  pc_step;

  assign accept  = instr_valid & instr_ready;
  assign rvc     = is_compressed(rdata);
  assign pc_step = rvc ? addr_t'(2) : addr_t'(4);

  assign instr_valid = (state == st_hold);
  // Next read goes out together with the accept
  assign req  = ~redirect & ((state == st_req) | ((state == st_hold) & instr_ready));
  assign addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      pc    <= '0;
    end else if (redirect) begin
      state <= st_req;  // Drops held beat and pending data
      pc    <= redirect_pc & PC_MASK & ~addr_t'(1);
    end else begin
      case (state)
        st_req:  if (gnt) state <= st_wait;
        st_wait: begin
          state <= st_hold;
          pc    <= (pc + pc_step) & PC_MASK;  // Wraps at end of memory
        end
        st_hold: if (accept) state <= gnt ? st_wait : st_req;  // Lost to APB
        default: state <= st_idle;
      endcase
    end
  end

  // Beat payload, held until accepted
  always_ff @(posedge clk) begin
    if (state == st_wait && !redirect) begin
      instr            <= rvc ? {16'h0000, rdata[15:0]} : rdata;
      instr_pc         <= pc;
      instr_compressed <= rvc;
    end
  end

endmodule

//--- logic/apb_store_port.sv
// APB4 store and readback port
`timescale 1ns/1ps

module apb_store_port #(
  parameter int MEM_SIZE = 4096
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  imem_pkg::addr_t paddr,
  input  imem_pkg::word_t pwdata,
  input  imem_pkg::strb_t pstrb,
  output imem_pkg::word_t prdata,
  output logic            pready,
  output logic            pslverr,
  // Towards the arbiter
  output logic            req,
  output logic            we,
  output imem_pkg::addr_t addr,
  output imem_pkg::word_t wdata,
  output imem_pkg::strb_t strb,
  input  logic            gnt,
  input  imem_pkg::word_t rdata
);
  import imem_pkg::*;

  localparam addr_t LIMIT = addr_t'(MEM_SIZE);  // First byte past the array

  logic access;    // APB access phase
  logic in_range;
  logic rd_phase;  // Second access cycle of a read

  assign access   = psel & penable;
  assign in_range = paddr < LIMIT;

  // One memory request per transfer, none when out of range
  assign req   = access & in_range & ~rd_phase;
  assign we    = pwrite;
  assign addr  = {paddr[ADDR_W-1:2], 2'b00};  // Word transfers only
  assign wdata = pwdata;
  assign strb  = pwrite ? pstrb : '0;

  // Writes and errors finish at once, reads one cycle later
  assign pready  = access & (~in_range | (pwrite & gnt) | rd_phase);
  assign pslverr = access & ~in_range;
  assign prdata  = rd_phase ? rdata : '0;  // Memory output lines up with pready

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_phase <= 1'b0;
    end else if (rd_phase) begin
      rd_phase <= 1'b0;                  // Transfer ends this cycle
    end else if (req && gnt && !pwrite) begin
      rd_phase <= 1'b1;
    end
  end

endmodule

//--- logic/imem_arbiter.sv
// Fixed-priority memory port arbiter
`timescale 1ns/1ps

module imem_arbiter (
  input  logic            clk,
  input  logic            rst_n,
  // APB peer, highest priority
  input  logic            apb_req,
  input  logic            apb_we,
  input  imem_pkg::addr_t apb_addr,
  input  imem_pkg::word_t apb_wdata,
  input  imem_pkg::strb_t apb_strb,
  output logic            apb_gnt,
  // Fetch peer, read only
  input  logic            fetch_req,
  input  imem_pkg::addr_t fetch_addr,
  output logic            fetch_gnt,
  // Single memory port
  output logic            mem_en,
  output logic            mem_we,
  output imem_pkg::addr_t mem_addr,
  output imem_pkg::word_t mem_wdata,
  output imem_pkg::strb_t mem_strb
);

  logic sel_apb;  // Address mux select
  logic rd_busy;  // Read granted last edge, data on the port now
  logic rd_apb;   // Owner of that read

  // APB always wins, fetch only in free cycles
  assign apb_gnt   = apb_req;
  assign fetch_gnt = fetch_req & ~apb_req;

  // Idle port keeps the last read owner's address, less toggling
  assign sel_apb = apb_req | (~fetch_req & rd_busy & rd_apb);

  assign mem_en    = apb_req | fetch_req;
  assign mem_we    = apb_req & apb_we;    // Fetch never writes
  assign mem_addr  = sel_apb ? apb_addr : fetch_addr;
  assign mem_wdata = apb_wdata;
  assign mem_strb  = mem_we ? apb_strb : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_busy <= 1'b0;
      rd_apb  <= 1'b0;
    end else begin
      rd_busy <= mem_en & ~mem_we;
      if (mem_en && !mem_we) begin
        rd_apb <= apb_gnt;  // Who gets rdata next cycle
      end
    end
  end

endmodule

//--- logic/instruction_memory.sv
// Byte-organised instruction memory
`timescale 1ns/1ps

module instruction_memory #(
  parameter int MEM_SIZE = 4096  // Bytes, power of two
) (
  input  logic            clk,
  input  logic            en,     // Port access this cycle
  input  logic            we,     // Write when set, read otherwise
  input  imem_pkg::addr_t addr,   // Byte address
  input  imem_pkg::word_t wdata,
  input  imem_pkg::strb_t strb,   // Byte lanes to write
  output imem_pkg::word_t rdata   // Valid the cycle after a read
);
  import imem_pkg::*;

  localparam int IDX_W = $clog2(MEM_SIZE);

  logic [7:0]       mem [MEM_SIZE];  // Little-endian byte store
  logic [IDX_W-1:0] rd_base;         // Halfword-aligned read start
  logic [IDX_W-1:0] wr_base;         // Word-aligned write start
  logic [IDX_W-1:0] rd_idx [STRB_W]; // Byte index per read lane

  // Fill with NOP words, low byte first
  initial begin
    for (int i = 0; i < MEM_SIZE; i += STRB_W) begin
      for (int b = 0; b < STRB_W; b++) begin
        mem[i + b] = nop_instr[8*b +: 8];
      end
    end
  end

  // Address bits above the array size are ignored
  assign rd_base = {addr[IDX_W-1:1], 1'b0};  // RVC needs halfword granularity
  assign wr_base = {addr[IDX_W-1:2], 2'b00};

  // A read may cross into the next word, index wraps at the top
  always_comb begin
    for (int k = 0; k < STRB_W; k++) begin
      rd_idx[k] = rd_base + IDX_W'(k);
    end
  end

  // Write lands at this edge; read data registered for next cycle
  always @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (strb[b]) begin
            mem[wr_base | IDX_W'(b)] <= wdata[8*b +: 8];  // Lane b only
          end
        end
      end else begin
        for (int k = 0; k < STRB_W; k++) begin
          rdata[8*k +: 8] <= mem[rd_idx[k]];
        end
      end
    end
  end

endmodule

//--- logic/imem_pkg.sv
// Instruction memory shared definitions
package imem_pkg;

  // RV32 only, XLEN fixed
  localparam int ADDR_W = 32;  // Byte address width
  localparam int WORD_W = 32;  // Fetch and store word
  localparam int STRB_W = WORD_W / 8;  // One enable per byte lane

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [STRB_W-1:0] strb_t;

  // ADDI x0,x0,0, reset contents of every word
  localparam word_t nop_instr = 32'h0000_0013;

  // RVC encodings use quadrants 0..2
  // Quadrant 3 (low bits 2'b11) is a full 32-bit instruction
  function automatic logic is_compressed(word_t w);
    return w[1:0] != 2'b11;
  endfunction

endpackage
